/* hw/routerPkg.sv */
package routerPkg;

  localparam int NumPorts = 5;

  //////////////////// flit types.
  typedef logic [2:0] flitKindT;
  typedef logic [15:0] flitDataT;
  typedef logic [11:0] pktLenT;
  typedef logic [2:0] portIdT;

  localparam flitKindT HeadKind = 3'd1; // any other kind is a body flit.

  typedef struct packed {
    flitKindT kind;
    flitDataT data; // head flit carries length in bits 11:0.
  } flitT;

  typedef struct packed {
    portIdT port;
    flitT flit;
  } outFlitT;

  typedef enum logic [2:0] {
    idle   = 3'd0,
    grantL = 3'd1,
    grantN = 3'd2,
    grantE = 3'd3,
    grantW = 3'd4,
    grantS = 3'd5
  } grantStateT;

  //////////////////// register map.
  typedef logic [7:0] axiAddrT;
  typedef logic [31:0] axiDataT;

  localparam axiAddrT RegCtrl   = 8'h00;
  localparam axiAddrT RegCountL = 8'h04;
  localparam axiAddrT RegCountN = 8'h08;
  localparam axiAddrT RegCountE = 8'h0C;
  localparam axiAddrT RegCountW = 8'h10;
  localparam axiAddrT RegCountS = 8'h14;

endpackage

/* hw/flitQueue.sv */
`timescale 1ns/1ps

module flitQueue #(
  parameter int FifoDepth = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  routerPkg::flitT inFlit,
  input  logic            inValid,
  output logic            inReady,
  output routerPkg::flitT headFlit,
  output logic            notEmpty,
  input  logic            pop
);

  localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntWidth = $clog2(FifoDepth + 1);

  routerPkg::flitT mem [FifoDepth];
  logic [PtrWidth-1:0] rdPtr;
  logic [PtrWidth-1:0] wrPtr;
  logic [CntWidth-1:0] used;
  logic full;
  logic push;
  logic doPop;

  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(FifoDepth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full = (used == CntWidth'(FifoDepth));
  assign notEmpty = (used != '0);
  assign doPop = pop && notEmpty;
  assign inReady = !full || doPop; // a full queue still takes a flit while popping.
  assign push = inValid && inReady;
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      used <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (doPop)
        rdPtr <= nextPtr(rdPtr);
      case ({push, doPop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used; // both or neither.
      endcase
    end
  end

endmodule

/* hw/packetTimer.sv */
`timescale 1ns/1ps

module packetTimer (
  input  logic              clk,
  input  logic              rst,
  input  logic              load,
  input  routerPkg::pktLenT loadLen,
  input  logic              advance,
  input  logic              clear,
  output logic              expired
);

  routerPkg::pktLenT lenQ;
  routerPkg::pktLenT count; // flits sent of the current packet.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lenQ <= '0;
      count <= '0;
    end
    else if (clear)
      count <= '0;
    else if (load)
    begin
      lenQ <= loadLen;
      count <= routerPkg::pktLenT'(1); // head counts as one.
    end
    else if (advance)
      count <= count + 1'b1;
  end

  // idle count never expires.
  assign expired = (count != '0) && (count == lenQ);

endmodule

/* hw/switchAllocator.sv */
`timescale 1ns/1ps

module switchAllocator (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [routerPkg::NumPorts-1:0]    request,
  input  routerPkg::flitT                   headFlit [routerPkg::NumPorts],
  output logic [routerPkg::NumPorts-1:0]    pop,
  input  logic                              enable,
  input  logic [routerPkg::NumPorts-1:0]    portMask,
  output routerPkg::outFlitT                outFlit,
  output logic                              outValid,
  input  logic                              outReady,
  output logic                              forwardPulse,
  output routerPkg::portIdT                 forwardPort
);

  localparam int NumPorts = routerPkg::NumPorts;

  routerPkg::grantStateT state;
  routerPkg::grantStateT nextState;
  logic [NumPorts-1:0] active;
  logic [NumPorts-1:0] granted;
  logic [NumPorts-1:0] hold;
  logic [NumPorts-1:0] expired;
  logic [NumPorts-1:0] isHead;
  routerPkg::portIdT curPort;
  routerPkg::flitT selFlit;
  logic outFree;

  assign active = request & portMask & {NumPorts{enable}}; // masked requests.
  assign outFree = !outValid || outReady;
  assign curPort = routerPkg::portIdT'(state - 1'b1);

  //////////////////// per port.
  for (genvar i = 0; i < NumPorts; i++)
  begin : gPort
    assign granted[i] = (state == routerPkg::grantStateT'(3'(i + 1)));
    assign hold[i] = active[i] && !expired[i];
    assign pop[i] = granted[i] && hold[i] && outFree;
    assign isHead[i] = (headFlit[i].kind == routerPkg::HeadKind);

    packetTimer timer_i (
      .clk     (clk),
      .rst     (rst),
      .load    (pop[i] && isHead[i]),
      .loadLen (headFlit[i].data[11:0]),
      .advance (pop[i] && !isHead[i]),
      .clear   (granted[i] && !hold[i]), // grant is leaving this port.
      .expired (expired[i])
    );
  end

  //////////////////// grant FSM.
  always_comb
  begin : nextStateLogic
    int base;
    int idx;
    logic found;
    nextState = routerPkg::idle;
    found = 1'b0;
    idx = 0;
    // search starts after the current port. from idle, at L.
    base = (state == routerPkg::idle) ? NumPorts - 1 : int'(curPort);
    if (|(granted & hold))
      nextState = state;
    else
    begin
      for (int k = 1; k <= NumPorts; k++)
      begin
        idx = (base + k) % NumPorts;
        if (!found && active[idx])
        begin
          nextState = routerPkg::grantStateT'(3'(idx + 1));
          found = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= routerPkg::idle;
      outValid <= 1'b0;
    end
    else
    begin
      state <= nextState;
      if (|pop)
        outValid <= 1'b1;
      else if (outReady)
        outValid <= 1'b0;
    end
  end

  //////////////////// output mux.
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (granted[i])
        selFlit = headFlit[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit.port <= curPort;
      outFlit.flit <= selFlit;
    end
  end

  assign forwardPulse = |pop;
  assign forwardPort = curPort; // valid only with forwardPulse.

endmodule

/* hw/routerRegs.sv */
`timescale 1ns/1ps

module routerRegs #(
  parameter int CountWidth = 32
) (
  input  logic                           clk,
  input  logic                           rst,
  input  routerPkg::axiAddrT             awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  routerPkg::axiDataT             wdata,
  input  logic [3:0]                     wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  routerPkg::axiAddrT             araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output routerPkg::axiDataT             rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  logic                           rready,
  output logic                           enable,
  output logic [routerPkg::NumPorts-1:0] portMask,
  input  logic                           forwardPulse,
  input  routerPkg::portIdT              forwardPort
);

  localparam int NumPorts = routerPkg::NumPorts;

  logic wrFire;
  logic rdFire;
  logic [NumPorts-1:0] clearCount;
  logic [CountWidth-1:0] count [NumPorts];
  routerPkg::axiDataT readValue;

  assign wrFire = awready && awvalid && wvalid;
  assign rdFire = arready && arvalid;
  assign bresp = 2'b00; // always OKAY.
  assign rresp = 2'b00;

  //////////////////// write channel.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
    end
    else
    begin
      awready <= 1'b0;
      wready <= 1'b0;
      if (awvalid && wvalid && !awready && !bvalid)
      begin
        awready <= 1'b1; // one cycle, both together.
        wready <= 1'b1;
      end
      if (wrFire)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      enable <= 1'b0;
      portMask <= '1;
    end
    else if (wrFire && awaddr == routerPkg::RegCtrl && wstrb[0])
    begin
      enable <= wdata[0];
      portMask <= wdata[NumPorts:1];
    end
  end

  always_comb
  begin
    clearCount = '0;
    if (wrFire)
    begin
      case (awaddr)
        routerPkg::RegCountL: clearCount[0] = 1'b1;
        routerPkg::RegCountN: clearCount[1] = 1'b1;
        routerPkg::RegCountE: clearCount[2] = 1'b1;
        routerPkg::RegCountW: clearCount[3] = 1'b1;
        routerPkg::RegCountS: clearCount[4] = 1'b1;
        default: clearCount = '0;
      endcase
    end
  end

  //////////////////// flit counters.
  for (genvar i = 0; i < NumPorts; i++)
  begin : gCount
    always_ff @(posedge clk)
    begin
      if (rst || clearCount[i])
        count[i] <= '0; // clear beats increment.
      else if (forwardPulse && forwardPort == routerPkg::portIdT'(i))
        count[i] <= count[i] + 1'b1;
    end
  end

  //////////////////// read channel.
  always_comb
  begin
    case (araddr)
      routerPkg::RegCtrl:   readValue = routerPkg::axiDataT'({portMask, enable});
      routerPkg::RegCountL: readValue = routerPkg::axiDataT'(count[0]);
      routerPkg::RegCountN: readValue = routerPkg::axiDataT'(count[1]);
      routerPkg::RegCountE: readValue = routerPkg::axiDataT'(count[2]);
      routerPkg::RegCountW: readValue = routerPkg::axiDataT'(count[3]);
      routerPkg::RegCountS: readValue = routerPkg::axiDataT'(count[4]);
      default:              readValue = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      arready <= 1'b0;
      rvalid <= 1'b0;
    end
    else
    begin
      arready <= 1'b0;
      if (arvalid && !arready && !rvalid)
        arready <= 1'b1;
      if (rdFire)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rdFire)
      rdata <= readValue;
  end

endmodule

/* hw/nocRouter.sv */
`timescale 1ns/1ps

module nocRouter #(
  parameter int FifoDepth  = 4,
  parameter int CountWidth = 32
) (
  input  logic                           clk,
  input  logic                           rst,
  input  routerPkg::flitT                inFlit [routerPkg::NumPorts],
  input  logic [routerPkg::NumPorts-1:0] inValid,
  output logic [routerPkg::NumPorts-1:0] inReady,
  output routerPkg::outFlitT             outFlit,
  output logic                           outValid,
  input  logic                           outReady,
  input  routerPkg::axiAddrT             awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  routerPkg::axiDataT             wdata,
  input  logic [3:0]                     wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  routerPkg::axiAddrT             araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output routerPkg::axiDataT             rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  logic                           rready
);

  logic [routerPkg::NumPorts-1:0] notEmpty;
  logic [routerPkg::NumPorts-1:0] pop;
  routerPkg::flitT headFlit [routerPkg::NumPorts];
  logic enable;
  logic [routerPkg::NumPorts-1:0] portMask;
  logic forwardPulse;
  routerPkg::portIdT forwardPort;

  // one input queue per port.
  for (genvar i = 0; i < routerPkg::NumPorts; i++)
  begin : gQueue
    flitQueue #(.FifoDepth(FifoDepth)) queue_i (
      .clk      (clk),
      .rst      (rst),
      .inFlit   (inFlit[i]),
      .inValid  (inValid[i]),
      .inReady  (inReady[i]),
      .headFlit (headFlit[i]),
      .notEmpty (notEmpty[i]),
      .pop      (pop[i])
    );
  end

  switchAllocator allocator_i (
    .clk, .rst, .request(notEmpty), .headFlit, .pop, .enable, .portMask,
    .outFlit, .outValid, .outReady, .forwardPulse, .forwardPort
  );

  routerRegs #(.CountWidth(CountWidth)) regs_i (
    .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
    .rvalid, .rready, .enable, .portMask, .forwardPulse, .forwardPort
  );

endmodule

/* test/routerModel.svh */
`ifndef ROUTER_MODEL_SVH
`define ROUTER_MODEL_SVH

// expected flits per port, in arrival order.
routerPkg::flitT expQ [routerPkg::NumPorts][$];
routerPkg::outFlitT orderQ [$]; // strict global order for the rotation test.
int modelCount [routerPkg::NumPorts];
bit strictOrder;
int blockedPort;

function automatic routerPkg::flitT makeHead(input int len);
  routerPkg::flitT f;
  f.kind = routerPkg::HeadKind;
  f.data = {4'($random(seed)), routerPkg::pktLenT'(len)}; // length in low 12 bits.
  return f;
endfunction

function automatic routerPkg::flitT makeBody();
  routerPkg::flitT f;
  f.kind = 3'($random(seed));
  if (f.kind == routerPkg::HeadKind)
    f.kind = 3'd0;
  f.data = 16'($random(seed));
  return f;
endfunction

function automatic bit drained(input logic [4:0] ports);
  for (int p = 0; p < routerPkg::NumPorts; p++)
  begin
    if (ports[p] && expQ[p].size() != 0)
      return 1'b0;
  end
  return 1'b1;
endfunction

task automatic modelPush(input int port, input routerPkg::flitT f);
  expQ[port].push_back(f);
endtask

// whole packets in port order, L first.
task automatic loadRotation();
  routerPkg::outFlitT o;
  for (int p = 0; p < routerPkg::NumPorts; p++)
  begin
    for (int i = 0; i < expQ[p].size(); i++)
    begin
      o.port = routerPkg::portIdT'(p);
      o.flit = expQ[p][i];
      orderQ.push_back(o);
    end
  end
endtask

task automatic modelOutput(input routerPkg::outFlitT o);
  int port;
  routerPkg::flitT expFlit;
  routerPkg::outFlitT expOut;
  port = int'(o.port);
  if (port >= routerPkg::NumPorts)
  begin
    noteFailure($sformatf("output flit names port %0d, which does not exist", port));
    return;
  end
  if (port == blockedPort)
    noteFailure($sformatf("flit from masked port %0d reached the output", port));
  modelCount[port]++;
  if (expQ[port].size() == 0)
    noteFailure($sformatf("flit from port %0d with none expected", port));
  else
  begin
    expFlit = expQ[port].pop_front();
    if (o.flit !== expFlit)
      valueMismatch($sformatf("outFlit.flit port %0d", port), 32'(expFlit), 32'(o.flit));
  end
  if (strictOrder)
  begin
    if (orderQ.size() == 0)
      noteFailure("output flit beyond the expected rotation");
    else
    begin
      expOut = orderQ.pop_front();
      if (o !== expOut)
        valueMismatch("outFlit", 32'(expOut), 32'(o));
    end
  end
endtask

`endif

/* test/routerTb.sv */
`timescale 1ns/1ps

module routerTb;

  localparam int FifoDepth = 4;
  localparam int CountWidth = 32;
  localparam int Timeout = 5000;
  localparam routerPkg::axiAddrT CountAddr [routerPkg::NumPorts] = '{
    routerPkg::RegCountL, routerPkg::RegCountN, routerPkg::RegCountE,
    routerPkg::RegCountW, routerPkg::RegCountS
  };

  logic clk;
  logic rst;
  routerPkg::flitT inFlit [routerPkg::NumPorts];
  logic [routerPkg::NumPorts-1:0] inValid;
  logic [routerPkg::NumPorts-1:0] inReady;
  routerPkg::outFlitT outFlit;
  logic outValid;
  logic outReady;
  routerPkg::axiAddrT awaddr;
  logic awvalid;
  logic awready;
  routerPkg::axiDataT wdata;
  logic [3:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  routerPkg::axiAddrT araddr;
  logic arvalid;
  logic arready;
  routerPkg::axiDataT rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;

  int seed;
  int readyMode; // 0 random, 1 high, 2 low.
  int valueErrors = 0;
  int otherErrors = 0;

  nocRouter #(.FifoDepth(FifoDepth), .CountWidth(CountWidth)) nocRouter_i (
    .clk, .rst, .inFlit, .inValid, .inReady, .outFlit, .outValid, .outReady,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready, .bresp, .bvalid,
    .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  task automatic valueMismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    valueErrors++;
    $display("[ERROR] %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
  endtask

  task automatic noteFailure(input string msg);
    otherErrors++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  `include "routerModel.svh"

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // back-pressure source.
  initial
  begin
    outReady = 1'b0;
    forever
    begin
      @(negedge clk);
      case (readyMode)
        0:       outReady = ({$random(seed)} % 3) != 0;
        1:       outReady = 1'b1;
        default: outReady = 1'b0;
      endcase
    end
  end

  //////////////////// output monitor.
  initial
  begin : outputMonitor
    routerPkg::outFlitT heldFlit;
    bit holding;
    holding = 1'b0;
    heldFlit = '0;
    forever
    begin
      @(posedge clk);
      if (!rst && holding && !outValid)
        valueMismatch("outValid", 32'h1, 32'(outValid));
      else if (!rst && holding && outFlit !== heldFlit)
        valueMismatch("outFlit", 32'(heldFlit), 32'(outFlit)); // must hold while stalled.
      if (!rst && outValid && outReady)
        modelOutput(outFlit);
      holding = !rst && outValid && !outReady;
      heldFlit = outFlit;
    end
  end

  //////////////////// stimulus.
  task automatic sendFlit(input int port, input routerPkg::flitT f);
    int waitCycles;
    bit taken;
    @(negedge clk);
    if ({$random(seed)} % 4 == 0)
    begin
      inValid[port] = 1'b0; // idle gap.
      @(negedge clk);
    end
    inFlit[port] = f;
    inValid[port] = 1'b1;
    waitCycles = 0;
    taken = 1'b0;
    while (!taken && waitCycles < Timeout)
    begin
      @(posedge clk);
      taken = inReady[port];
      waitCycles++;
    end
    if (taken)
      modelPush(port, f);
    else
      noteFailure($sformatf("port %0d did not accept a flit", port));
  endtask

  task automatic sendPackets(input int port, input int numPkts, input int minLen,
                             input int maxLen);
    int len;
    for (int n = 0; n < numPkts; n++)
    begin
      len = minLen + {$random(seed)} % (maxLen - minLen + 1);
      for (int i = 0; i < len; i++)
        sendFlit(port, (i == 0) ? makeHead(len) : makeBody());
    end
    @(negedge clk);
    inValid[port] = 1'b0;
  endtask

  task automatic waitDrain(input logic [4:0] ports);
    int waitCycles;
    bit done;
    waitCycles = 0;
    done = 1'b0;
    while (!done && waitCycles < Timeout)
    begin
      @(negedge clk);
      done = drained(ports) && !outValid;
      waitCycles++;
    end
    if (!done)
      noteFailure("timeout waiting for the queues to drain");
  endtask

  task automatic waitQueuesFull();
    int waitCycles;
    waitCycles = 0;
    @(negedge clk);
    while (inReady !== '0 && waitCycles < Timeout)
    begin
      @(negedge clk);
      waitCycles++;
    end
    if (inReady !== '0)
      noteFailure("inReady stayed high with the output stalled");
  endtask

  //////////////////// AXI4-Lite.
  task automatic axiWrite(input routerPkg::axiAddrT addr, input routerPkg::axiDataT data);
    int waitCycles;
    bit done;
    @(negedge clk);
    awaddr = addr;
    wdata = data;
    wstrb = 4'hF;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b1;
    waitCycles = 0;
    done = 1'b0;
    while (!done && waitCycles < Timeout)
    begin
      @(posedge clk);
      done = awready;
      waitCycles++;
    end
    if (!done)
      noteFailure("AXI write address was never accepted");
    else if (wready !== 1'b1)
      valueMismatch("wready", 32'h1, 32'(wready)); // rises with awready.
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    waitCycles = 0;
    done = 1'b0;
    while (!done && waitCycles < Timeout)
    begin
      @(posedge clk);
      done = bvalid;
      waitCycles++;
    end
    if (!done)
      noteFailure("AXI write response never arrived");
    else if (bresp !== 2'b00)
      valueMismatch("bresp", 32'h0, 32'(bresp));
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axiRead(input routerPkg::axiAddrT addr, output routerPkg::axiDataT data);
    int waitCycles;
    bit done;
    @(negedge clk);
    araddr = addr;
    arvalid = 1'b1;
    rready = 1'b1;
    waitCycles = 0;
    done = 1'b0;
    data = '0;
    while (!done && waitCycles < Timeout)
    begin
      @(posedge clk);
      done = arready;
      waitCycles++;
    end
    if (!done)
      noteFailure("AXI read address was never accepted");
    @(negedge clk);
    arvalid = 1'b0;
    waitCycles = 0;
    done = 1'b0;
    while (!done && waitCycles < Timeout)
    begin
      @(posedge clk);
      done = rvalid;
      data = rdata;
      waitCycles++;
    end
    if (!done)
      noteFailure("AXI read data never arrived");
    else if (rresp !== 2'b00)
      valueMismatch("rresp", 32'h0, 32'(rresp));
    @(negedge clk);
    rready = 1'b0;
  endtask

  // a write of any value clears a counter.
  task automatic checkCounters();
    routerPkg::axiDataT rd;
    for (int p = 0; p < routerPkg::NumPorts; p++)
    begin
      axiRead(CountAddr[p], rd);
      if (rd !== routerPkg::axiDataT'(modelCount[p]))
        valueMismatch($sformatf("rdata count %0d", p), 32'(modelCount[p]), rd);
      axiWrite(CountAddr[p], 32'hFFFF_FFFF);
      modelCount[p] = 0;
      axiRead(CountAddr[p], rd);
      if (rd !== '0)
        valueMismatch($sformatf("rdata cleared count %0d", p), 32'h0, rd);
    end
  endtask

  //////////////////// main sequence.
  initial
  begin
    routerPkg::axiDataT rd;
    seed = 84230;
    readyMode = 2;
    strictOrder = 1'b0;
    blockedPort = -1;
    inValid = '0;
    for (int p = 0; p < routerPkg::NumPorts; p++)
    begin
      inFlit[p] = '0;
      modelCount[p] = 0;
    end
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // reset values.
    @(negedge clk);
    if (outValid !== 1'b0)
      valueMismatch("outValid", 32'h0, 32'(outValid));
    if (inReady !== 5'h1F)
      valueMismatch("inReady", 32'h1F, 32'(inReady));
    axiRead(routerPkg::RegCtrl, rd);
    if (rd !== 32'h3E)
      valueMismatch("rdata RegCtrl", 32'h3E, rd);

    // random traffic, random back-pressure.
    axiWrite(routerPkg::RegCtrl, 32'h3F);
    readyMode = 0;
    fork
      sendPackets(0, 8, 1, 6);
      sendPackets(1, 8, 1, 6);
      sendPackets(2, 8, 1, 6);
      sendPackets(3, 8, 1, 6);
      sendPackets(4, 8, 1, 6);
    join
    waitDrain(5'h1F);
    checkCounters();

    // rotation. packets fit the queues so each one runs unbroken.
    axiWrite(routerPkg::RegCtrl, 32'h3E);
    fork
      sendPackets(0, 1, 1, FifoDepth);
      sendPackets(1, 1, 1, FifoDepth);
      sendPackets(2, 1, 1, FifoDepth);
      sendPackets(3, 1, 1, FifoDepth);
      sendPackets(4, 1, 1, FifoDepth);
    join
    loadRotation();
    strictOrder = 1'b1;
    readyMode = 1;
    axiWrite(routerPkg::RegCtrl, 32'h3F);
    waitDrain(5'h1F);
    strictOrder = 1'b0;
    if (orderQ.size() != 0)
      noteFailure("rotation ended before all expected flits came out");

    // East masked off.
    axiWrite(routerPkg::RegCtrl, 32'h37);
    blockedPort = 2;
    readyMode = 0;
    fork
      sendPackets(0, 2, 1, 6);
      sendPackets(1, 2, 1, 6);
      sendPackets(2, 1, 1, FifoDepth);
      sendPackets(3, 2, 1, 6);
      sendPackets(4, 2, 1, 6);
    join
    waitDrain(5'h1B);
    if (expQ[2].size() == 0)
      noteFailure("masked port has no flits left waiting");
    blockedPort = -1;
    axiWrite(routerPkg::RegCtrl, 32'h3F);
    waitDrain(5'h1F);

    // stall the output until every queue is full.
    readyMode = 2;
    fork
      sendPackets(0, 2, 3, 6);
      sendPackets(1, 2, 3, 6);
      sendPackets(2, 2, 3, 6);
      sendPackets(3, 2, 3, 6);
      sendPackets(4, 2, 3, 6);
      begin
        waitQueuesFull();
        repeat (20) @(negedge clk);
        readyMode = 0;
      end
    join
    waitDrain(5'h1F);
    checkCounters();

    $display("value errors: %0d, other failures: %0d", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* nocRouter.f */
+incdir+test
hw/routerPkg.sv
hw/flitQueue.sv
hw/packetTimer.sv
hw/switchAllocator.sv
hw/routerRegs.sv
hw/nocRouter.sv
test/routerTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := routerTb
FILELIST  := nocRouter.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
HEADERS   := test/routerModel.svh
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
